/* src.f */
tlc_pkg.sv
phase_timer_if.sv
phase_timer.sv
tlc_sequencer.sv
lamp_decoder.sv
tlc_top.sv
tb_tlc.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_tlc
RTL_TOP    := tlc_top
FILELIST   := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tb_tlc.sv */
`timescale 1ns/1ps

module tb_tlc;

    localparam int TICKS = 4;  // Clock cycles per second in simulation

    logic clk;
    logic rst;
    tlc_pkg::secs_t n_duration, e_duration, s_duration, w_duration;
    tlc_pkg::secs_t yellow_duration, red_holding;

    logic N_red, N_yellow, N_green;
    logic E_red, E_yellow, E_green;
    logic S_red, S_yellow, S_green;
    logic W_red, W_yellow, W_green;
    tlc_pkg::secs_t  countdown_sec;
    tlc_pkg::dir_t   active_direction;
    tlc_pkg::count_t yellow_light_count;

    logic [15:0] lfsr_state;
    int          phase_cyc    = 0;  // Cycles since current phase began
    int          phases_done  = 0;  // Lamp changes seen by the checker
    int          yellow_total = 0;  // Reference yellow entries without wrap

    tlc_top #(.TICKS_PER_SEC(TICKS)) tlc_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // ======================================================================
    // Random durations
    // ======================================================================
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16,14,13,11
    endfunction

    // Four fresh bits folded into 1..5
    task automatic random_duration(output tlc_pkg::secs_t d);
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < 4; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[2:0], lfsr_state[0]};
        end
        d = tlc_pkg::secs_t'(v % 4'd5) + tlc_pkg::secs_t'(1);
    endtask

    task automatic randomize_durations();
        random_duration(n_duration);
        random_duration(e_duration);
        random_duration(s_duration);
        random_duration(w_duration);
        random_duration(yellow_duration);
        random_duration(red_holding);
    endtask

    task automatic set_durations(input tlc_pkg::secs_t d);
        n_duration      = d;
        e_duration      = d;
        s_duration      = d;
        w_duration      = d;
        yellow_duration = d;
        red_holding     = d;
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic tlc_pkg::phase_t next_phase(input tlc_pkg::phase_t p);
        tlc_pkg::phase_t n;
        int              idx;
        idx    = (int'(p.dir) * 3 + int'(p.kind) + 1) % 12;  // Ring of twelve
        n.dir  = tlc_pkg::dir_t'(2'(idx / 3));
        n.kind = tlc_pkg::phase_kind_t'(2'(idx % 3));
        return n;
    endfunction

    function automatic tlc_pkg::lamps_t expected_lamps(input tlc_pkg::phase_t p);
        tlc_pkg::lamps_t l;
        logic [3:0]      sel;
        sel      = 4'b0001 << p.dir;
        l.red    = 4'b1111;  // All-red unless served
        l.yellow = '0;
        l.green  = '0;
        if (p.kind == tlc_pkg::PH_GREEN) begin
            l.green = sel;
            l.red   = ~sel;
        end else if (p.kind == tlc_pkg::PH_YELLOW) begin
            l.yellow = sel;
            l.red    = ~sel;
        end
        return l;
    endfunction

    // Seconds a phase runs from the port value at its start
    function automatic int phase_seconds(input tlc_pkg::phase_t p);
        tlc_pkg::secs_t d;
        case (p.kind)
            tlc_pkg::PH_GREEN: begin
                case (p.dir)
                    tlc_pkg::DIR_NORTH: d = n_duration;
                    tlc_pkg::DIR_EAST:  d = e_duration;
                    tlc_pkg::DIR_SOUTH: d = s_duration;
                    default:            d = w_duration;
                endcase
            end
            tlc_pkg::PH_YELLOW: d = yellow_duration;
            default:            d = red_holding;
        endcase
        return (d == '0) ? 1 : int'(d);  // Zero runs as one second
    endfunction

    // Zero on the change cycle then loaded and one down per second
    function automatic tlc_pkg::secs_t expected_remaining(input int cyc, input int secs);
        if (cyc == 0) begin
            return '0;
        end
        return tlc_pkg::secs_t'(secs - (cyc - 1) / TICKS);
    endfunction

    function automatic tlc_pkg::lamps_t observed_lamps();
        tlc_pkg::lamps_t l;
        l.red    = {W_red, S_red, E_red, N_red};
        l.yellow = {W_yellow, S_yellow, E_yellow, N_yellow};
        l.green  = {W_green, S_green, E_green, N_green};
        return l;
    endfunction

    // ======================================================================
    // Compare tasks
    // ======================================================================
    task automatic stop_run(input string why);
        $display("Regression failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_lamps(input string name, input tlc_pkg::lamps_t exp,
                               input tlc_pkg::lamps_t act);
        if (act !== exp) begin
            $display("FAILED time=%0t %s expected=%03h actual=%03h", $time, name, exp, act);
            stop_run("lamp pattern mismatch");
        end
    endtask

    task automatic check_dir(input string name, input tlc_pkg::dir_t exp,
                             input tlc_pkg::dir_t act);
        if (act !== exp) begin
            $display("FAILED time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
            stop_run("direction mismatch");
        end
    endtask

    task automatic check_secs(input string name, input tlc_pkg::secs_t exp,
                              input tlc_pkg::secs_t act);
        if (act !== exp) begin
            $display("FAILED time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
            stop_run("countdown mismatch");
        end
    endtask

    task automatic check_count(input string name, input tlc_pkg::count_t exp,
                               input tlc_pkg::count_t act);
        if (act !== exp) begin
            $display("FAILED time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
            stop_run("yellow count mismatch");
        end
    endtask

    task automatic check_state(input tlc_pkg::phase_t p, input tlc_pkg::secs_t secs,
                               input tlc_pkg::count_t cnt);
        check_lamps("lamps {red,yellow,green}", expected_lamps(p), observed_lamps());
        check_dir("active_direction", p.dir, active_direction);
        check_secs("countdown_sec", secs, countdown_sec);
        check_count("yellow_light_count", cnt, yellow_light_count);
    endtask

    // ======================================================================
    // Checker sampling 1 ns after each rising edge
    // ======================================================================
    initial begin : compare_proc
        tlc_pkg::phase_t exp_phase;
        int              secs;
        int              guard;
        exp_phase = tlc_pkg::RESET_PHASE;
        guard     = 0;
        @(posedge clk);
        #1;
        while (rst) begin
            check_state(exp_phase, '0, '0);  // Held in reset state
            guard++;
            if (guard > 20) begin
                stop_run("reset was never released");
            end
            @(posedge clk);
            #1;
        end
        secs = phase_seconds(exp_phase);  // First edge after release starts North green
        forever begin
            if (phase_cyc == secs * TICKS + 2) begin
                exp_phase = next_phase(exp_phase);
                if (exp_phase.kind == tlc_pkg::PH_YELLOW) begin
                    yellow_total++;
                end
                secs      = phase_seconds(exp_phase);
                phase_cyc = 0;
                phases_done++;
            end
            check_state(exp_phase, expected_remaining(phase_cyc, secs),
                        tlc_pkg::count_t'(yellow_total));
            @(posedge clk);
            #1;
            phase_cyc++;
        end
    end

    // ======================================================================
    // Stimulus driven on falling edges
    // ======================================================================
    initial begin : stimulus
        int guard;
        int target;
        lfsr_state = 16'd20;
        rst        = 1'b1;
        randomize_durations();
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // Two full cycles with new durations mid-phase
        guard = 0;
        while (phases_done < 24) begin
            @(negedge clk);
            if (phase_cyc == 3) begin
                randomize_durations();
            end
            guard++;
            if (guard > 24 * 22 + 50) begin
                stop_run("random duration cycles did not complete");
            end
        end

        // Zero durations run each phase for one second
        set_durations('0);
        target = phases_done + 13;
        guard  = 0;
        while (phases_done < target) begin
            @(negedge clk);
            guard++;
            if (guard > 13 * 22 + 50) begin
                stop_run("zero duration cycle did not complete");
            end
        end

        // Short phases until the yellow counter wraps
        set_durations(tlc_pkg::secs_t'(1));
        guard = 0;
        while (yellow_total < 300) begin
            @(negedge clk);
            guard++;
            if (guard > 300 * 3 * 6 + 200) begin
                stop_run("yellow counter run did not complete");
            end
        end

        @(negedge clk);
        check_count("yellow_light_count", tlc_pkg::count_t'(yellow_total),
                    yellow_light_count);
        $display("Regression passed");
        $finish;
    end

endmodule

/* tlc_top.sv */
`timescale 1ns/1ps

module tlc_top #(
    parameter int TICKS_PER_SEC = 100_000_000  // Small value in simulation
) (
    input  logic            clk,
    input  logic            rst,
    input  tlc_pkg::secs_t  n_duration,       // Green lengths, seconds
    input  tlc_pkg::secs_t  e_duration,
    input  tlc_pkg::secs_t  s_duration,
    input  tlc_pkg::secs_t  w_duration,
    input  tlc_pkg::secs_t  yellow_duration,
    input  tlc_pkg::secs_t  red_holding,
    output logic            N_red,
    output logic            N_yellow,
    output logic            N_green,
    output logic            E_red,
    output logic            E_yellow,
    output logic            E_green,
    output logic            S_red,
    output logic            S_yellow,
    output logic            S_green,
    output logic            W_red,
    output logic            W_yellow,
    output logic            W_green,
    output tlc_pkg::secs_t  countdown_sec,      // Seconds left in phase
    output tlc_pkg::dir_t   active_direction,
    output tlc_pkg::count_t yellow_light_count  // Yellow entries, mod 256
);

    tlc_pkg::phase_t phase;
    tlc_pkg::lamps_t lamps;

    phase_timer_if tmr_bus ();

    // ======================================================================
    // Blocks
    // ======================================================================
    tlc_sequencer tlc_sequencer_inst (
        .clk             (clk),
        .rst             (rst),
        .n_duration      (n_duration),
        .e_duration      (e_duration),
        .s_duration      (s_duration),
        .w_duration      (w_duration),
        .yellow_duration (yellow_duration),
        .red_holding     (red_holding),
        .tmr             (tmr_bus),
        .phase           (phase),
        .yellow_count    (yellow_light_count)
    );

    phase_timer #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) phase_timer_inst (
        .clk (clk),
        .rst (rst),
        .tmr (tmr_bus)
    );

    lamp_decoder lamp_decoder_inst (
        .phase            (phase),
        .lamps            (lamps),
        .active_direction (active_direction)
    );

    assign countdown_sec = tmr_bus.remaining;

    // Split lamp vectors, bit 0 North .. bit 3 West
    assign N_red    = lamps.red[0];
    assign N_yellow = lamps.yellow[0];
    assign N_green  = lamps.green[0];
    assign E_red    = lamps.red[1];
    assign E_yellow = lamps.yellow[1];
    assign E_green  = lamps.green[1];
    assign S_red    = lamps.red[2];
    assign S_yellow = lamps.yellow[2];
    assign S_green  = lamps.green[2];
    assign W_red    = lamps.red[3];
    assign W_yellow = lamps.yellow[3];
    assign W_green  = lamps.green[3];

endmodule

/* lamp_decoder.sv */
`timescale 1ns/1ps

module lamp_decoder (
    input  tlc_pkg::phase_t phase,
    output tlc_pkg::lamps_t lamps,
    output tlc_pkg::dir_t   active_direction
);

    // ======================================================================
    // Lamp pattern per phase
    // ======================================================================
    always_comb begin
        // Every direction red by default
        lamps.red    = 4'b1111;
        lamps.yellow = 4'b0000;
        lamps.green  = 4'b0000;

        case (phase.kind)
            tlc_pkg::PH_GREEN: begin
                lamps.red[phase.dir]   = 1'b0;
                lamps.green[phase.dir] = 1'b1;
            end
            tlc_pkg::PH_YELLOW: begin
                lamps.red[phase.dir]    = 1'b0;
                lamps.yellow[phase.dir] = 1'b1;
            end
            default: begin
                // All-red clearance keeps the defaults
            end
        endcase
    end

    // Direction stays active through its all-red phase
    assign active_direction = phase.dir;

endmodule

/* tlc_sequencer.sv */
`timescale 1ns/1ps

module tlc_sequencer (
    input  logic            clk,
    input  logic            rst,
    input  tlc_pkg::secs_t  n_duration,       // Green lengths per direction
    input  tlc_pkg::secs_t  e_duration,
    input  tlc_pkg::secs_t  s_duration,
    input  tlc_pkg::secs_t  w_duration,
    input  tlc_pkg::secs_t  yellow_duration,  // Shared by all directions
    input  tlc_pkg::secs_t  red_holding,      // Shared all-red hold
    phase_timer_if.ctrl     tmr,
    output tlc_pkg::phase_t phase,
    output tlc_pkg::count_t yellow_count
);

    logic            run;        // Set from first clock after reset
    tlc_pkg::phase_t phase_nxt;  // Successor of current phase
    tlc_pkg::phase_t target;     // Phase the next request times
    tlc_pkg::secs_t  dur_sel;
    tlc_pkg::secs_t  seconds_q;

    // ======================================================================
    // Phase order
    // ======================================================================
    function automatic tlc_pkg::phase_t advance(input tlc_pkg::phase_t cur);
        tlc_pkg::phase_t nxt;
        nxt = cur;
        case (cur.kind)
            tlc_pkg::PH_GREEN:  nxt.kind = tlc_pkg::PH_YELLOW;
            tlc_pkg::PH_YELLOW: nxt.kind = tlc_pkg::PH_ALL_RED;
            default: begin
                // All-red done, next direction, West wraps to North
                nxt.kind = tlc_pkg::PH_GREEN;
                nxt.dir  = tlc_pkg::dir_t'(cur.dir + 2'd1);
            end
        endcase
        return nxt;
    endfunction

    assign phase_nxt = advance(phase);

    // On ack the request that follows belongs to the successor
    assign target = tmr.ack ? phase_nxt : phase;

    // Duration lookup for target phase
    always_comb begin
        case (target.kind)
            tlc_pkg::PH_GREEN: begin
                case (target.dir)
                    tlc_pkg::DIR_NORTH: dur_sel = n_duration;
                    tlc_pkg::DIR_EAST:  dur_sel = e_duration;
                    tlc_pkg::DIR_SOUTH: dur_sel = s_duration;
                    default:            dur_sel = w_duration;
                endcase
            end
            tlc_pkg::PH_YELLOW: dur_sel = yellow_duration;
            default:            dur_sel = red_holding;
        endcase
    end

    // ======================================================================
    // Handshake
    // ======================================================================
    // Req drops in the ack cycle and returns as soon as ack is low
    assign tmr.req     = run & ~tmr.ack;
    assign tmr.seconds = seconds_q;

    // Sampled only while req is low, so stable for a whole request
    always_ff @(posedge clk) begin
        if (!tmr.req) begin
            seconds_q <= dur_sel;
        end
    end

    // ======================================================================
    // Phase register and yellow counter
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run          <= 1'b0;
            phase        <= tlc_pkg::RESET_PHASE;
            yellow_count <= '0;
        end else begin
            run <= 1'b1;
            if (tmr.ack) begin
                phase <= phase_nxt;  // Lamps change on this edge
                if (phase_nxt.kind == tlc_pkg::PH_YELLOW) begin
                    yellow_count <= yellow_count + tlc_pkg::count_t'(1);  // Wraps at 256
                end
            end
        end
    end

endmodule

/* phase_timer.sv */
`timescale 1ns/1ps

module phase_timer #(
    parameter int TICKS_PER_SEC = 100_000_000  // Clock cycles per second
) (
    input  logic        clk,
    input  logic        rst,
    phase_timer_if.timer tmr
);

    // Prescaler needs at least one bit even for one tick per second
    localparam int PRESC_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(TICKS_PER_SEC - 1);

    logic [PRESC_W-1:0] presc;        // Cycle count within current second
    logic               busy;         // Counting a phase
    logic               ack_q;
    tlc_pkg::secs_t     remaining_q;
    logic               latch;        // First cycle of a new request
    logic               sec_tick;     // Prescaler wrap

    // New request only once the previous ack has been retired
    assign latch    = tmr.req & ~busy & ~ack_q;
    assign sec_tick = busy & (presc == PRESC_LAST);

    // ======================================================================
    // Prescaler and seconds countdown
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            presc       <= '0;
            busy        <= 1'b0;
            ack_q       <= 1'b0;
            remaining_q <= '0;
        end else begin
            if (latch) begin
                // Zero length would never expire, run it as one second
                if (tmr.seconds == '0) begin
                    remaining_q <= tlc_pkg::secs_t'(1);
                end else begin
                    remaining_q <= tmr.seconds;
                end
                presc <= '0;
                busy  <= 1'b1;
            end else if (busy) begin
                if (sec_tick) begin
                    presc       <= '0;
                    remaining_q <= remaining_q - tlc_pkg::secs_t'(1);
                    // Last second gone, hand back to sequencer
                    if (remaining_q == tlc_pkg::secs_t'(1)) begin
                        busy  <= 1'b0;
                        ack_q <= 1'b1;
                    end
                end else begin
                    presc <= presc + PRESC_W'(1);
                end
            end else if (ack_q && !tmr.req) begin
                ack_q <= 1'b0;  // Req seen low, close handshake
            end
        end
    end

    assign tmr.ack       = ack_q;
    assign tmr.remaining = remaining_q;  // Holds zero until next latch

endmodule

/* phase_timer_if.sv */
`timescale 1ns/1ps

// Four-phase req/ack link between sequencer and phase timer
interface phase_timer_if;

    logic           req;        // Sequencer wants a phase timed
    tlc_pkg::secs_t seconds;    // Length of that phase, stable while req high
    logic           ack;        // Timer done, phase expired
    tlc_pkg::secs_t remaining;  // Live countdown in seconds

    // Sequencer side
    modport ctrl (
        output req,
        output seconds,
        input  ack,
        input  remaining
    );

    // Timer side
    modport timer (
        input  req,
        input  seconds,
        output ack,
        output remaining
    );

endinterface

/* tlc_pkg.sv */
package tlc_pkg;

    // ======================================================================
    // Direction and phase encodings
    // ======================================================================

    // Fixed service order, N -> E -> S -> W
    typedef enum logic [1:0] {
        DIR_NORTH = 2'd0,
        DIR_EAST  = 2'd1,
        DIR_SOUTH = 2'd2,
        DIR_WEST  = 2'd3
    } dir_t;

    // Three phases per direction
    typedef enum logic [1:0] {
        PH_GREEN   = 2'd0,
        PH_YELLOW  = 2'd1,
        PH_ALL_RED = 2'd2
    } phase_kind_t;

    // One of the twelve phases
    typedef struct packed {
        dir_t        dir;
        phase_kind_t kind;
    } phase_t;

    // Lamp vectors, bit 0 North .. bit 3 West
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] yellow;
        logic [3:0] green;
    } lamps_t;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int SEC_W   = 8;  // Durations and countdown, seconds
    localparam int COUNT_W = 8;  // Yellow entry counter

    typedef logic [SEC_W-1:0]   secs_t;
    typedef logic [COUNT_W-1:0] count_t;

    // Phase entered from reset
    localparam phase_t RESET_PHASE = '{dir: DIR_NORTH, kind: PH_GREEN};

endpackage
